// File: rtl/operand_requester_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module operand_requester_fsm #(
  parameter vrf_opreq_pkg::opqueue_e QueueId = vrf_opreq_pkg::AluA
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Command from the lane sequencer
  input  vrf_opreq_pkg::opreq_cmd_t           cmd_i,
  input  logic                                cmd_valid_i,
  output logic                                cmd_ready_o,
  // Operand queue and instruction status
  input  logic                                queue_ready_i,
  input  vrf_opreq_pkg::vid_mask_t            vinsn_running_i,
  input  vrf_opreq_pkg::vid_mask_t            result_written_i,
  // Bank arbiters
  output logic [vrf_opreq_pkg::NrBanks-1:0]   bank_req_o,
  output vrf_opreq_pkg::vrf_bank_req_t        payload_o,
  input  logic [vrf_opreq_pkg::NrBanks-1:0]   gnt_i,
  output logic                                issued_o
);

  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

  state_e                    state_d, state_q;
  vrf_opreq_pkg::vaddr_t     addr_d, addr_q;
  vrf_opreq_pkg::vlen_t      len_d, len_q;
  vrf_opreq_pkg::eew_e       eew_d, eew_q;
  vrf_opreq_pkg::vid_mask_t  hazard_d, hazard_q;

  vrf_opreq_pkg::vlen_t      elems;
  logic                      stall;

  // Elements held in one 64-bit word
  assign elems = vrf_opreq_pkg::vlen_t'(4'd8 >> eew_q);

  // Wait while a producer we depend on wrote nothing last cycle
  assign stall = |(hazard_q & ~result_written_i);

  assign issued_o = |gnt_i;

  // Reads only, the bank row is the address above the bank bits
  always_comb begin
    payload_o         = '0;
    payload_o.addr    = addr_q[$bits(vrf_opreq_pkg::vaddr_t)-1:vrf_opreq_pkg::BankSelW];
    payload_o.opqueue = QueueId;
  end

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    addr_d      = addr_q;
    len_d       = len_q;
    eew_d       = eew_q;
    hazard_d    = hazard_q;
    bank_req_o  = '0;
    cmd_ready_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        cmd_ready_o = 1'b1;
      end

      REQUESTING: begin
        // Drop dependences on instructions that have retired
        hazard_d = hazard_q & vinsn_running_i;

        if (queue_ready_i) begin
          bank_req_o[addr_q[vrf_opreq_pkg::BankSelW-1:0]] = !stall;

          if (issued_o) begin
            addr_d = addr_q + 1'b1;
            len_d  = (len_q > elems) ? len_q - elems : '0;

            // Last word granted, take the next command in the same cycle
            if (len_d == '0) begin
              state_d     = IDLE;
              cmd_ready_o = 1'b1;
            end
          end
        end
      end

      default: state_d = IDLE;
    endcase

    // Accept a command
    if (cmd_ready_o && cmd_valid_i) begin
      addr_d   = vrf_opreq_pkg::vaddr_t'(cmd_i.vs * vrf_opreq_pkg::VregWords);
      len_d    = cmd_i.vl;
      eew_d    = cmd_i.eew;
      hazard_d = cmd_i.hazard;
      // Zero length is acknowledged and dropped
      state_d  = (cmd_i.vl == '0) ? IDLE : REQUESTING;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      addr_q   <= '0;
      len_q    <= '0;
      eew_q    <= vrf_opreq_pkg::EW64;
      hazard_q <= '0;
    end else begin
      state_q  <= state_d;
      addr_q   <= addr_d;
      len_q    <= len_d;
      eew_q    <= eew_d;
      hazard_q <= hazard_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/vfu_write_ports.sv
`timescale 1ns/1ps
`default_nettype none

// Port 0 is the ALU, port 1 the load unit
module vfu_write_ports (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // ALU result port
  input  vrf_opreq_pkg::vfu_result_t           alu_result_i,
  input  logic                                 alu_result_req_i,
  output logic                                 alu_result_gnt_o,
  // Load unit result port
  input  vrf_opreq_pkg::vfu_result_t           ldu_result_i,
  input  logic                                 ldu_result_req_i,
  output logic                                 ldu_result_gnt_o,
  // Bank arbiters
  output logic [vrf_opreq_pkg::NrMasters-vrf_opreq_pkg::NrOpQueues-1:0]
               [vrf_opreq_pkg::NrBanks-1:0]    bank_req_o,
  output vrf_opreq_pkg::vrf_bank_req_t
         [vrf_opreq_pkg::NrMasters-vrf_opreq_pkg::NrOpQueues-1:0] payload_o,
  input  logic [vrf_opreq_pkg::NrMasters-vrf_opreq_pkg::NrOpQueues-1:0]
               [vrf_opreq_pkg::NrBanks-1:0]    gnt_i,
  // Hazard tracking for the requesters
  output vrf_opreq_pkg::vid_mask_t             result_written_o
);

  function automatic vrf_opreq_pkg::vrf_bank_req_t to_bank_req(
    input vrf_opreq_pkg::vfu_result_t res
  );
    vrf_opreq_pkg::vrf_bank_req_t req;
    req       = '0;
    req.addr  = res.addr[$bits(vrf_opreq_pkg::vaddr_t)-1:vrf_opreq_pkg::BankSelW];
    req.wen   = 1'b1;
    req.wdata = res.wdata;
    req.be    = res.be;
    return req;
  endfunction

  ////////////////////////////////////////////////////////////
  // Load stream register
  ////////////////////////////////////////////////////////////

  vrf_opreq_pkg::vfu_result_t ldu_q;
  logic                       ldu_valid_q;
  logic                       ldu_drain;

  assign ldu_drain        = |gnt_i[1];
  assign ldu_result_gnt_o = ldu_result_req_i && (!ldu_valid_q || ldu_drain);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ldu_valid_q <= 1'b0;
    end else if (ldu_result_gnt_o) begin
      ldu_valid_q <= 1'b1;
    end else if (ldu_drain) begin
      ldu_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldu_result_gnt_o) begin
      ldu_q <= ldu_result_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Bank requests and grants
  ////////////////////////////////////////////////////////////

  // ALU goes straight to its bank
  assign alu_result_gnt_o = |gnt_i[0];

  always_comb begin
    bank_req_o = '0;
    bank_req_o[0][alu_result_i.addr[vrf_opreq_pkg::BankSelW-1:0]] = alu_result_req_i;
    bank_req_o[1][ldu_q.addr[vrf_opreq_pkg::BankSelW-1:0]]        = ldu_valid_q;

    payload_o[0] = to_bank_req(alu_result_i);
    payload_o[1] = to_bank_req(ldu_q);
  end

  // Which instructions wrote a word this cycle
  vrf_opreq_pkg::vid_mask_t written_d;

  always_comb begin
    written_d                   = '0;
    written_d[alu_result_i.id] |= alu_result_gnt_o;
    written_d[ldu_q.id]        |= ldu_drain;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_written_o <= '0;
    end else begin
      result_written_o <= written_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/vrf_bank_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_bank_arbiter (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  logic [vrf_opreq_pkg::NrMasters-1:0]                       req_i,
  input  vrf_opreq_pkg::vrf_bank_req_t [vrf_opreq_pkg::NrMasters-1:0] payload_i,
  output logic [vrf_opreq_pkg::NrMasters-1:0]                       gnt_o,
  output logic                                                      vrf_req_o,
  output vrf_opreq_pkg::vrf_bank_req_t                              vrf_bank_o
);

  typedef logic [$clog2(vrf_opreq_pkg::NrMasters)-1:0] master_idx_t;

  // First requesting slot at or after the pointer, within size slots
  function automatic logic [1:0] rr_pick(
    input logic [2:0] req,
    input logic [1:0] ptr,
    input logic [1:0] size
  );
    logic [2:0] idx;
    logic       found;
    logic [1:0] win;
    found = 1'b0;
    win   = ptr;
    for (int i = 0; i < 3; i++) begin
      idx = {1'b0, ptr} + 3'(i);
      if (idx >= {1'b0, size}) begin
        idx = idx - {1'b0, size};
      end
      if (!found && (i < int'(size)) && req[idx[1:0]]) begin
        found = 1'b1;
        win   = idx[1:0];
      end
    end
    return win;
  endfunction

  function automatic logic [1:0] next_ptr(input logic [1:0] win, input logic [1:0] size);
    return (win == size - 2'd1) ? 2'd0 : win + 2'd1;
  endfunction

  ////////////////////////////////////////////////////////////
  // Class vectors
  ////////////////////////////////////////////////////////////

  logic [2:0]  hp_req;
  logic [2:0]  lp_req;
  logic [1:0]  hp_ptr_d, hp_ptr_q;
  logic [1:0]  lp_ptr_d, lp_ptr_q;
  logic [1:0]  hp_win;
  logic [1:0]  lp_win;
  master_idx_t win_master;

  // High class slots are ALU A, ALU B and ALU write
  assign hp_req = {req_i[vrf_opreq_pkg::NrOpQueues],
                   req_i[vrf_opreq_pkg::AluB],
                   req_i[vrf_opreq_pkg::AluA]};

  // Low class slots are store data and load write
  assign lp_req = {1'b0,
                   req_i[vrf_opreq_pkg::NrOpQueues + 1],
                   req_i[vrf_opreq_pkg::StoreD]};

  assign hp_win    = rr_pick(hp_req, hp_ptr_q, 2'd3);
  assign lp_win    = rr_pick(lp_req, lp_ptr_q, 2'd2);
  assign vrf_req_o = |req_i;

  ////////////////////////////////////////////////////////////
  // Grant
  ////////////////////////////////////////////////////////////

  always_comb begin
    hp_ptr_d   = hp_ptr_q;
    lp_ptr_d   = lp_ptr_q;
    win_master = '0;
    gnt_o      = '0;
    vrf_bank_o = '0;

    // Any high class request masks the low class
    if (|hp_req) begin
      hp_ptr_d = next_ptr(hp_win, 2'd3);
      unique case (hp_win)
        2'd0:    win_master = master_idx_t'(vrf_opreq_pkg::AluA);
        2'd1:    win_master = master_idx_t'(vrf_opreq_pkg::AluB);
        default: win_master = master_idx_t'(vrf_opreq_pkg::NrOpQueues);
      endcase
    end else if (|lp_req) begin
      lp_ptr_d = next_ptr(lp_win, 2'd2);
      if (lp_win == 2'd0) begin
        win_master = master_idx_t'(vrf_opreq_pkg::StoreD);
      end else begin
        win_master = master_idx_t'(vrf_opreq_pkg::NrOpQueues + 1);
      end
    end

    if (vrf_req_o) begin
      gnt_o[win_master] = 1'b1;
      vrf_bank_o        = payload_i[win_master];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hp_ptr_q <= '0;
      lp_ptr_q <= '0;
    end else begin
      hp_ptr_q <= hp_ptr_d;
      lp_ptr_q <= lp_ptr_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/vrf_opreq_pkg.sv
`default_nettype none

package vrf_opreq_pkg;

  ////////////////////////////////////////////////////////////
  // Lane geometry
  ////////////////////////////////////////////////////////////

  localparam int unsigned NrBanks    = 4;
  localparam int unsigned BankSelW   = 2;
  localparam int unsigned NrOpQueues = 3;
  localparam int unsigned NrVInsn    = 8;
  localparam int unsigned VregWords  = 8;
  // Read masters first, then ALU write and load write
  localparam int unsigned NrMasters  = 5;

  ////////////////////////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////////////////////////

  typedef logic [63:0] word_t;
  typedef logic [7:0]  strb_t;
  // Low BankSelW bits select the bank
  typedef logic [7:0]  vaddr_t;
  typedef logic [5:0]  bank_addr_t;
  typedef logic [2:0]  vid_t;
  typedef logic [7:0]  vid_mask_t;
  typedef logic [9:0]  vlen_t;
  typedef logic [4:0]  vreg_t;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Also the master index of each read requester
  typedef enum logic [1:0] {
    AluA   = 2'd0,
    AluB   = 2'd1,
    StoreD = 2'd2
  } opqueue_e;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    vreg_t     vs;
    eew_e      eew;
    vlen_t     vl;
    vid_mask_t hazard;
  } opreq_cmd_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    word_t  wdata;
    strb_t  be;
  } vfu_result_t;

  typedef struct packed {
    bank_addr_t addr;
    logic       wen;
    word_t      wdata;
    strb_t      be;
    opqueue_e   opqueue;
  } vrf_bank_req_t;

endpackage

`default_nettype wire

// File: rtl/vrf_opreq_top.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_opreq_top (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  // Operand requests, one per queue
  input  vrf_opreq_pkg::opreq_cmd_t [vrf_opreq_pkg::NrOpQueues-1:0]   operand_request_i,
  input  logic [vrf_opreq_pkg::NrOpQueues-1:0]                        operand_request_valid_i,
  output logic [vrf_opreq_pkg::NrOpQueues-1:0]                        operand_request_ready_o,
  input  logic [vrf_opreq_pkg::NrOpQueues-1:0]                        operand_queue_ready_i,
  output logic [vrf_opreq_pkg::NrOpQueues-1:0]                        operand_issued_o,
  input  vrf_opreq_pkg::vid_mask_t                                    vinsn_running_i,
  // Result writes
  input  vrf_opreq_pkg::vfu_result_t                                  alu_result_i,
  input  logic                                                        alu_result_req_i,
  output logic                                                        alu_result_gnt_o,
  input  vrf_opreq_pkg::vfu_result_t                                  ldu_result_i,
  input  logic                                                        ldu_result_req_i,
  output logic                                                        ldu_result_gnt_o,
  // VRF banks
  output logic [vrf_opreq_pkg::NrBanks-1:0]                           vrf_req_o,
  output vrf_opreq_pkg::vrf_bank_req_t [vrf_opreq_pkg::NrBanks-1:0]   vrf_bank_o
);

  // Master by bank, as the requesters see it
  logic [vrf_opreq_pkg::NrMasters-1:0][vrf_opreq_pkg::NrBanks-1:0]  mst_req;
  logic [vrf_opreq_pkg::NrMasters-1:0][vrf_opreq_pkg::NrBanks-1:0]  mst_gnt;
  vrf_opreq_pkg::vrf_bank_req_t [vrf_opreq_pkg::NrMasters-1:0]      mst_payload;
  // Bank by master, as the arbiters see it
  logic [vrf_opreq_pkg::NrBanks-1:0][vrf_opreq_pkg::NrMasters-1:0]  bank_req;
  logic [vrf_opreq_pkg::NrBanks-1:0][vrf_opreq_pkg::NrMasters-1:0]  bank_gnt;
  vrf_opreq_pkg::vid_mask_t                                         result_written;

  ////////////////////////////////////////////////////////////
  // Read requesters
  ////////////////////////////////////////////////////////////

  for (genvar q = 0; q < vrf_opreq_pkg::NrOpQueues; q++) begin : gen_requester
    operand_requester_fsm #(
      .QueueId(vrf_opreq_pkg::opqueue_e'(q))
    ) u_requester (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .cmd_i           (operand_request_i[q]),
      .cmd_valid_i     (operand_request_valid_i[q]),
      .cmd_ready_o     (operand_request_ready_o[q]),
      .queue_ready_i   (operand_queue_ready_i[q]),
      .vinsn_running_i (vinsn_running_i),
      .result_written_i(result_written),
      .bank_req_o      (mst_req[q]),
      .payload_o       (mst_payload[q]),
      .gnt_i           (mst_gnt[q]),
      .issued_o        (operand_issued_o[q])
    );
  end

  vfu_write_ports u_write_ports (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .alu_result_i    (alu_result_i),
    .alu_result_req_i(alu_result_req_i),
    .alu_result_gnt_o(alu_result_gnt_o),
    .ldu_result_i    (ldu_result_i),
    .ldu_result_req_i(ldu_result_req_i),
    .ldu_result_gnt_o(ldu_result_gnt_o),
    .bank_req_o      (mst_req[vrf_opreq_pkg::NrMasters-1:vrf_opreq_pkg::NrOpQueues]),
    .payload_o       (mst_payload[vrf_opreq_pkg::NrMasters-1:vrf_opreq_pkg::NrOpQueues]),
    .gnt_i           (mst_gnt[vrf_opreq_pkg::NrMasters-1:vrf_opreq_pkg::NrOpQueues]),
    .result_written_o(result_written)
  );

  ////////////////////////////////////////////////////////////
  // One arbiter per bank
  ////////////////////////////////////////////////////////////

  for (genvar b = 0; b < vrf_opreq_pkg::NrBanks; b++) begin : gen_bank
    for (genvar m = 0; m < vrf_opreq_pkg::NrMasters; m++) begin : gen_transpose
      assign bank_req[b][m] = mst_req[m][b];
      assign mst_gnt[m][b]  = bank_gnt[b][m];
    end

    vrf_bank_arbiter u_arbiter (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .req_i     (bank_req[b]),
      .payload_i (mst_payload),
      .gnt_o     (bank_gnt[b]),
      .vrf_req_o (vrf_req_o[b]),
      .vrf_bank_o(vrf_bank_o[b])
    );
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the operand requester testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_vrf_opreq \
  -f vrf_opreq.f \
  -o sim_tb_vrf_opreq

./obj_dir/sim_tb_vrf_opreq > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
fi
exit 1

// File: tests/tb_vrf_opreq.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vrf_opreq;

  localparam int unsigned WaitLimit  = 300;
  // Cycle budget per test, summed for the watchdog
  localparam int unsigned TestBudget = 6 * WaitLimit + 4 * WaitLimit + 2 * WaitLimit
                                       + 7 * WaitLimit + 7 * WaitLimit + 2 * WaitLimit + 60;
  localparam int unsigned WatchdogNs = (TestBudget + 100) * 40;

  typedef struct packed {
    logic [31:0]               cyc;
    logic [1:0]                bank;
    vrf_opreq_pkg::bank_addr_t row;
  } rd_ent_t;

  typedef struct packed {
    logic [1:0]                bank;
    vrf_opreq_pkg::bank_addr_t row;
    vrf_opreq_pkg::word_t      wdata;
    vrf_opreq_pkg::strb_t      be;
  } wr_ent_t;

  logic                                                       clk_i;
  logic                                                       rst_ni;
  vrf_opreq_pkg::opreq_cmd_t [vrf_opreq_pkg::NrOpQueues-1:0]  operand_request_i;
  logic [vrf_opreq_pkg::NrOpQueues-1:0]                       operand_request_valid_i;
  logic [vrf_opreq_pkg::NrOpQueues-1:0]                       operand_request_ready_o;
  logic [vrf_opreq_pkg::NrOpQueues-1:0]                       operand_queue_ready_i;
  logic [vrf_opreq_pkg::NrOpQueues-1:0]                       operand_issued_o;
  vrf_opreq_pkg::vid_mask_t                                   vinsn_running_i;
  vrf_opreq_pkg::vfu_result_t                                 alu_result_i;
  logic                                                       alu_result_req_i;
  logic                                                       alu_result_gnt_o;
  vrf_opreq_pkg::vfu_result_t                                 ldu_result_i;
  logic                                                       ldu_result_req_i;
  logic                                                       ldu_result_gnt_o;
  logic [vrf_opreq_pkg::NrBanks-1:0]                          vrf_req_o;
  vrf_opreq_pkg::vrf_bank_req_t [vrf_opreq_pkg::NrBanks-1:0]  vrf_bank_o;

  logic [31:0] seed;
  logic [31:0] cyc;
  int          errors;
  int          ntests;
  int          issued_cnt [3];
  // Load results accepted and not yet written to a bank
  int          ldu_held;
  rd_ent_t     rd_log [3][$];
  wr_ent_t     wr_log [$];

  vrf_opreq_top dut0 (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .operand_request_i      (operand_request_i),
    .operand_request_valid_i(operand_request_valid_i),
    .operand_request_ready_o(operand_request_ready_o),
    .operand_queue_ready_i  (operand_queue_ready_i),
    .operand_issued_o       (operand_issued_o),
    .vinsn_running_i        (vinsn_running_i),
    .alu_result_i           (alu_result_i),
    .alu_result_req_i       (alu_result_req_i),
    .alu_result_gnt_o       (alu_result_gnt_o),
    .ldu_result_i           (ldu_result_i),
    .ldu_result_req_i       (ldu_result_req_i),
    .ldu_result_gnt_o       (ldu_result_gnt_o),
    .vrf_req_o              (vrf_req_o),
    .vrf_bank_o             (vrf_bank_o)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 32'd1;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic report_fail(input string msg);
    errors++;
    $display("Fail %0t: %s", $time, msg);
  endtask

  // Words in a run, rounded up to whole 64-bit words
  function automatic int exp_words(input int vl, input int eew);
    int per;
    per = 8 >> eew;
    return (vl + per - 1) / per;
  endfunction

  function automatic vrf_opreq_pkg::opreq_cmd_t make_cmd(
    input int vs, input int eew, input int vl, input logic [7:0] hazard
  );
    vrf_opreq_pkg::opreq_cmd_t c;
    c.vs     = vrf_opreq_pkg::vreg_t'(vs);
    c.eew    = vrf_opreq_pkg::eew_e'(eew[1:0]);
    c.vl     = vrf_opreq_pkg::vlen_t'(vl);
    c.hazard = hazard;
    return c;
  endfunction

  task automatic clear_logs();
    for (int q = 0; q < 3; q++) begin
      rd_log[q].delete();
      issued_cnt[q] = 0;
    end
    wr_log.delete();
  endtask

  task automatic end_test(input string name, input int errs_before);
    ntests++;
    $display("test %0d %s: %0d errors", ntests, name, errors - errs_before);
  endtask

  // Holds valid until the requester takes the command
  task automatic send_cmd(input int q, input vrf_opreq_pkg::opreq_cmd_t cmd);
    int n;
    n = 0;
    operand_request_i[q]       = cmd;
    operand_request_valid_i[q] = 1'b1;
    @(negedge clk_i);
    while (!operand_request_ready_o[q] && n < WaitLimit) begin
      @(negedge clk_i);
      n++;
    end
    if (!operand_request_ready_o[q]) begin
      errors++;
      $display("Requester %0d never accepted its command", q);
    end
    @(posedge clk_i);
    #2;
    operand_request_valid_i[q] = 1'b0;
  endtask

  task automatic wait_ready(input int q);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!operand_request_ready_o[q] && n < WaitLimit) begin
      @(negedge clk_i);
      n++;
    end
    if (!operand_request_ready_o[q]) begin
      errors++;
      $display("Requester %0d never finished its read run", q);
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  // Reads of one run must walk consecutive words from vs * VregWords
  task automatic check_run(input int q, input int vs, input int first, input int n);
    vrf_opreq_pkg::vaddr_t a;
    for (int i = 0; i < n; i++) begin
      a = vrf_opreq_pkg::vaddr_t'(vs * vrf_opreq_pkg::VregWords + i);
      if (first + i >= rd_log[q].size()) begin
        report_fail($sformatf("queue %0d is missing read %0d", q, i));
        return;
      end
      assert (rd_log[q][first+i].bank == a[1:0] && rd_log[q][first+i].row == a[7:2])
        else report_fail($sformatf("queue %0d read %0d at wrong address", q, i));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bank monitor
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : monitor
    rd_ent_t re;
    wr_ent_t we;
    int      nrd [3];
    int      ld_wr;
    logic    exp_ldu_gnt;
    if (rst_ni) begin
      nrd   = '{0, 0, 0};
      ld_wr = 0;
      for (int b = 0; b < vrf_opreq_pkg::NrBanks; b++) begin
        if (vrf_req_o[b] && vrf_bank_o[b].wen) begin
          we.bank  = 2'(b);
          we.row   = vrf_bank_o[b].addr;
          we.wdata = vrf_bank_o[b].wdata;
          we.be    = vrf_bank_o[b].be;
          wr_log.push_back(we);
          ld_wr++;
        end else if (vrf_req_o[b]) begin
          re.cyc  = cyc;
          re.bank = 2'(b);
          re.row  = vrf_bank_o[b].addr;
          assert (int'(vrf_bank_o[b].opqueue) < 3)
            else report_fail("read granted with an unknown opqueue");
          if (int'(vrf_bank_o[b].opqueue) < 3) begin
            rd_log[int'(vrf_bank_o[b].opqueue)].push_back(re);
            nrd[int'(vrf_bank_o[b].opqueue)]++;
          end
        end
      end
      for (int q = 0; q < 3; q++) begin
        if (operand_issued_o[q]) issued_cnt[q]++;
        assert (nrd[q] == int'(operand_issued_o[q]))
          else report_fail($sformatf("issued pulse of queue %0d without matching read", q));
      end
      // Writes other than the ALU one drain the load stream register
      if (alu_result_gnt_o) begin
        ld_wr--;
      end
      exp_ldu_gnt = ldu_result_req_i && (ldu_held == 0 || ld_wr > 0);
      assert (ldu_result_gnt_o == exp_ldu_gnt)
        else report_fail("load grant does not follow the stream register state");
      ldu_held = ldu_held - ld_wr + int'(ldu_result_gnt_o);
    end
  end

  ////////////////////////////////////////////////////////////
  // Cycle rules
  ////////////////////////////////////////////////////////////

  ap_issue_needs_queue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (operand_issued_o & ~operand_queue_ready_i) == '0)
    else report_fail("read issued while operand queue not ready");

  ap_alu_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alu_result_gnt_o |-> alu_result_req_i)
    else report_fail("ALU grant without request");

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial begin : watchdog
    #(WatchdogNs);
    $display("Timeout: the run did not finish within its cycle budget");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    int                        e0;
    int                        vs;
    int                        eew;
    int                        vl;
    int                        nw;
    int                        win0;
    int                        win1;
    int                        n;
    vrf_opreq_pkg::word_t      exp_data [4];
    vrf_opreq_pkg::strb_t      exp_be [4];

    clk_i                   = 1'b0;
    rst_ni                  = 1'b0;
    seed                    = 32'h7784;
    cyc                     = '0;
    errors                  = 0;
    ntests                  = 0;
    ldu_held                = 0;
    operand_request_i       = '0;
    operand_request_valid_i = '0;
    operand_queue_ready_i   = '1;
    vinsn_running_i         = '0;
    alu_result_i            = '0;
    alu_result_req_i        = 1'b0;
    ldu_result_i            = '0;
    ldu_result_req_i        = 1'b0;
    clear_logs();
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    idle_cycles(1);

    // Lone command per queue
    e0 = errors;
    for (int q = 0; q < 3; q++) begin
      clear_logs();
      vs  = int'(lcg() % 32);
      eew = int'(lcg() % 4);
      vl  = 1 + int'(lcg() % 40);
      nw  = exp_words(vl, eew);
      send_cmd(q, make_cmd(vs, eew, vl, 8'h00));
      wait_ready(q);
      assert (issued_cnt[q] == nw && rd_log[q].size() == nw)
        else report_fail($sformatf("queue %0d issued %0d, expected %0d", q, issued_cnt[q], nw));
      check_run(q, vs, 0, nw);
    end
    end_test("lone read", e0);

    // Zero length, then two commands back to back
    e0 = errors;
    clear_logs();
    send_cmd(0, make_cmd(3, 3, 0, 8'h00));
    idle_cycles(5);
    assert (issued_cnt[0] == 0 && operand_request_ready_o[0])
      else report_fail("zero-length command started reads");
    send_cmd(0, make_cmd(4, 3, 4, 8'h00));
    send_cmd(0, make_cmd(9, 3, 4, 8'h00));
    wait_ready(0);
    assert (rd_log[0].size() == 8)
      else report_fail("back-to-back commands lost reads");
    if (rd_log[0].size() == 8) begin
      assert (rd_log[0][7].cyc - rd_log[0][0].cyc == 32'd7)
        else report_fail("idle cycle between back-to-back commands");
    end
    check_run(0, 4, 0, 4);
    check_run(0, 9, 4, 4);
    end_test("zero length and back to back", e0);

    // Hazard stall released by a write, then by retirement
    e0 = errors;
    clear_logs();
    vinsn_running_i = 8'h08;
    send_cmd(1, make_cmd(6, 3, 4, 8'h08));
    idle_cycles(6);
    assert (issued_cnt[1] == 0) else report_fail("read issued under hazard");
    alu_result_i     = '{id: 3'd3, addr: 8'h02, wdata: 64'h1, be: 8'hff};
    alu_result_req_i = 1'b1;
    @(negedge clk_i);
    assert (alu_result_gnt_o) else report_fail("ALU write not granted");
    @(posedge clk_i);
    #2;
    alu_result_req_i = 1'b0;
    idle_cycles(4);
    assert (issued_cnt[1] == 1)
      else report_fail($sformatf("expected one read after write, saw %0d", issued_cnt[1]));
    vinsn_running_i = 8'h00;
    wait_ready(1);
    assert (issued_cnt[1] == 4) else report_fail("reads did not resume after retirement");
    check_run(1, 6, 0, 4);
    end_test("hazard stall", e0);

    // ALU write beats store read, ALU A and B alternate
    e0 = errors;
    clear_logs();
    operand_queue_ready_i[2] = 1'b0;
    send_cmd(2, make_cmd(0, 3, 1, 8'h00));
    alu_result_i             = '{id: 3'd0, addr: 8'h04, wdata: 64'h2, be: 8'h0f};
    alu_result_req_i         = 1'b1;
    operand_queue_ready_i[2] = 1'b1;
    @(negedge clk_i);
    assert (alu_result_gnt_o && !operand_issued_o[2] && vrf_bank_o[0].wen)
      else report_fail("store read was not held behind the ALU write");
    @(posedge clk_i);
    #2;
    alu_result_req_i = 1'b0;
    @(negedge clk_i);
    assert (operand_issued_o[2]) else report_fail("store read not granted after write");
    wait_ready(2);
    operand_queue_ready_i[1:0] = 2'b00;
    send_cmd(0, make_cmd(1, 3, 1, 8'h00));
    send_cmd(1, make_cmd(1, 3, 1, 8'h00));
    operand_queue_ready_i[1:0] = 2'b11;
    @(negedge clk_i);
    assert ($countones(operand_issued_o[1:0]) == 1)
      else report_fail("ALU A and B granted together on one bank");
    win0 = operand_issued_o[0] ? 0 : 1;
    @(posedge clk_i);
    #2;
    // Loser waits while the winner gets a fresh read on the same bank
    operand_queue_ready_i[1:0] = 2'b00;
    send_cmd(win0, make_cmd(1, 3, 1, 8'h00));
    operand_queue_ready_i[1:0] = 2'b11;
    @(negedge clk_i);
    assert ($countones(operand_issued_o[1:0]) == 1)
      else report_fail("ALU A and B granted together on one bank");
    win1 = operand_issued_o[0] ? 0 : 1;
    wait_ready(0);
    wait_ready(1);
    assert (win0 != win1) else report_fail("ALU A and B did not alternate");
    end_test("bank contention", e0);

    // Load burst into bank 1 while ALU A sweeps all banks
    e0 = errors;
    clear_logs();
    send_cmd(0, make_cmd(0, 3, 24, 8'h00));
    for (int k = 0; k < 4; k++) begin
      exp_data[k]      = {lcg(), lcg()};
      exp_be[k]        = vrf_opreq_pkg::strb_t'(lcg());
      ldu_result_i     = '{id: 3'd5, addr: {6'(k), 2'b01}, wdata: exp_data[k], be: exp_be[k]};
      ldu_result_req_i = 1'b1;
      n = 0;
      @(negedge clk_i);
      while (!ldu_result_gnt_o && n < WaitLimit) begin
        @(negedge clk_i);
        n++;
      end
      if (!ldu_result_gnt_o) begin
        errors++;
        $display("Load result %0d was never accepted", k);
      end
      @(posedge clk_i);
      #2;
    end
    ldu_result_req_i = 1'b0;
    n = 0;
    while (wr_log.size() < 4 && n < WaitLimit) begin
      idle_cycles(1);
      n++;
    end
    wait_ready(0);
    assert (wr_log.size() == 4)
      else report_fail($sformatf("%0d load writes reached the banks", wr_log.size()));
    for (int k = 0; k < 4 && k < wr_log.size(); k++) begin
      assert (wr_log[k].bank == 2'd1 && wr_log[k].row == 6'(k)
              && wr_log[k].wdata == exp_data[k] && wr_log[k].be == exp_be[k])
        else report_fail($sformatf("load write %0d corrupted or out of order", k));
    end
    check_run(0, 0, 0, 24);
    end_test("load burst", e0);

    // Operand queue full
    e0 = errors;
    clear_logs();
    operand_queue_ready_i[2] = 1'b0;
    send_cmd(2, make_cmd(2, 3, 4, 8'h00));
    idle_cycles(8);
    assert (issued_cnt[2] == 0) else report_fail("read issued while queue full");
    assert (dut0.gen_requester[2].u_requester.len_q == vrf_opreq_pkg::vlen_t'(4))
      else report_fail("remaining count changed while queue full");
    operand_queue_ready_i[2] = 1'b1;
    wait_ready(2);
    assert (issued_cnt[2] == 4) else report_fail("queue ready did not resume reads");
    check_run(2, 2, 0, 4);
    end_test("queue not ready", e0);

    $display("%0d tests run, %0d errors", ntests, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vrf_opreq.f
rtl/vrf_opreq_pkg.sv
rtl/operand_requester_fsm.sv
rtl/vfu_write_ports.sv
rtl/vrf_bank_arbiter.sv
rtl/vrf_opreq_top.sv
tests/tb_vrf_opreq.sv
